//--- source/pipePkg.sv
////////////////////////////////////////
// shared widths and control types of the pipeline control block
// an all-zero stage value is a bubble in every stage
////////////////////////////////////////
package pipePkg;

	// 32 architectural registers
	localparam int regAddrWidth = 5;

	// register address as seen by the hazard logic
	// address zero is hardwired and never needs a bypass
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// control fields that one instruction carries through the back end
	typedef struct packed {
		// result goes back to the register file
		logic regWrite;
		// result comes from data memory (load)
		logic memToReg;
		// store to data memory
		logic memWrite;
		// first source operand
		regAddr_t rs;
		// second source operand
		regAddr_t rt;
		// destination register
		regAddr_t writeReg;
	} stageCtrl_t;

	// empty slot loaded on reset and on an Execute flush
	localparam stageCtrl_t ctrlBubble = '0;

	// control flow of the instruction sitting in Decode
	typedef struct packed {
		// conditional branch
		logic branch;
		logic jump;
		logic jalr;
		// comparator says the branch in Decode is taken
		logic brTaken;
	} branchInfo_t;

	// operand source of the Execute ALU inputs
	typedef enum logic [1:0] {
		// plain register file value
		fwdNone = 2'b00,
		// result of the instruction in Writeback
		fwdW    = 2'b01,
		// ALU result of the instruction in Memory
		fwdM    = 2'b10
	} fwdSel_t;

	// all bypass selects toward the datapath
	typedef struct packed {
		// Decode operands for the early branch compare
		logic    forwardAD;
		logic    forwardBD;
		// Execute operands
		fwdSel_t forwardAE;
		fwdSel_t forwardBE;
	} forward_t;

	// stall and flush commands toward the pipeline registers
	typedef struct packed {
		logic stallF;
		logic stallD;
		logic flushD;
		logic flushE;
		// holds Execute, Memory and Writeback together
		logic stallBack;
		// a load or store occupies Memory
		logic memAccessM;
	} hazardCmd_t;

endpackage

//--- source/forwardUnit.sv
////////////////////////////////////////
// bypass selects from register address matches
// Memory wins over Writeback and r0 never forwards
////////////////////////////////////////
module forwardUnit (
	// instruction in Decode
	input  pipePkg::stageCtrl_t ctrlD,
	// instructions in flight
	input  pipePkg::stageCtrl_t ctrlE,
	input  pipePkg::stageCtrl_t ctrlM,
	input  pipePkg::stageCtrl_t ctrlW,
	// selects toward the operand muxes
	output pipePkg::forward_t   fwd
);

	// src is a live operand that the given stage is about to write
	function automatic logic writesSrc(
		input pipePkg::regAddr_t   src,
		input pipePkg::stageCtrl_t stage
	);
		logic live;
		// r0 always reads as zero so it never depends on anything
		live = (src != '0);
		return live && (src == stage.writeReg) && stage.regWrite;
	endfunction

	// Execute operand source with Memory ahead of Writeback
	function automatic pipePkg::fwdSel_t selExec(
		input pipePkg::regAddr_t   src,
		input pipePkg::stageCtrl_t m,
		input pipePkg::stageCtrl_t w
	);
		pipePkg::fwdSel_t sel;
		if (writesSrc(src, m)) begin
			// youngest producer holds the newest value
			sel = pipePkg::fwdM;
		end else if (writesSrc(src, w)) begin
			sel = pipePkg::fwdW;
		end else begin
			sel = pipePkg::fwdNone;
		end
		return sel;
	endfunction

	// ex to ex and mem to ex bypass
	always_comb begin
		fwd.forwardAE = selExec(ctrlE.rs, ctrlM, ctrlW);
		fwd.forwardBE = selExec(ctrlE.rt, ctrlM, ctrlW);
	end

	// Decode operands for the branch comparator
	// only the Memory ALU result is routed back to Decode
	// a producer still in Execute is handled by the branch stall instead
	always_comb begin
		fwd.forwardAD = writesSrc(ctrlD.rs, ctrlM);
		fwd.forwardBD = writesSrc(ctrlD.rt, ctrlM);
	end

endmodule

//--- source/hazardUnit.sv
////////////////////////////////////////
// stall and flush commands for the five-stage pipe
// branches resolve in Decode and loads return in Writeback
////////////////////////////////////////
module hazardUnit (
	// instruction in Decode
	input  pipePkg::stageCtrl_t  ctrlD,
	// instructions in Execute and Memory
	input  pipePkg::stageCtrl_t  ctrlE,
	input  pipePkg::stageCtrl_t  ctrlM,
	// control flow of the Decode instruction
	input  pipePkg::branchInfo_t brInfoD,
	// data memory not ready
	input  logic                 dWait,
	// commands toward the pipeline registers
	output pipePkg::hazardCmd_t  cmd
);

	// load or store sitting in Memory
	logic memAccess;
	// data memory back-pressure
	logic memStall;
	// Execute destination matches a Decode source
	logic hitE;
	// Memory destination matches a Decode source
	logic hitM;
	// Decode instruction reads registers for its control flow
	logic brDep;
	// load result needed by the very next instruction
	logic loadUseStall;
	// branch or jalr operand not yet available in Decode
	logic branchStall;
	// any reason to freeze fetch and decode
	logic anyStall;
	// Decode redirects fetch this cycle
	logic redirect;

	// destination compares against both Decode sources
	// r0 is not excluded here so a write to r0 still stalls
	always_comb begin
		hitE = (ctrlE.writeReg == ctrlD.rs) || (ctrlE.writeReg == ctrlD.rt);
		hitM = (ctrlM.writeReg == ctrlD.rs) || (ctrlM.writeReg == ctrlD.rt);
	end

	// memory side
	always_comb begin
		memAccess = ctrlM.memToReg | ctrlM.memWrite;
		// only an access in flight waits on the memory
		memStall = dWait & memAccess;
	end

	// data hazards that bypassing cannot cover
	always_comb begin
		// load in Execute followed by a consumer in Decode
		loadUseStall = ctrlE.memToReg & hitE;

		// jump needs no register so it never waits here
		brDep = brInfoD.branch | brInfoD.jalr;

		// any writer in Execute is too late for the Decode compare
		// a load in Memory only has data in Writeback
		branchStall = brDep & ((ctrlE.regWrite & hitE) | (ctrlM.memToReg & hitM));

		anyStall = loadUseStall | branchStall | memStall;
	end

	// control flow redirect out of Decode
	always_comb begin
		// branch and jalr are not evaluated until their operands are ready
		// comparator result only counts for a conditional branch
		// jump has no operand so it always redirects
		redirect = (brInfoD.branch & brInfoD.brTaken & ~branchStall)
			| brInfoD.jump
			| (brInfoD.jalr & ~branchStall);
	end

	// command outputs
	// a register is never held and flushed in the same cycle
	// so the flushes give way to the memory stall
	always_comb begin
		cmd.stallF     = anyStall;
		cmd.stallD     = anyStall;
		// wrong path instruction in Decode
		cmd.flushD     = redirect & ~memStall;
		// bubble into Execute while Decode waits
		cmd.flushE     = (loadUseStall | branchStall) & ~memStall;
		// whole back end waits on the data memory
		cmd.stallBack  = memStall;
		cmd.memAccessM = memAccess;
	end

endmodule

//--- source/pipeCtrl.sv
////////////////////////////////////////
// Execute, Memory and Writeback control registers with hazard logic
// fwd and cmd are combinational from ctrlD, brInfoD and dWait
////////////////////////////////////////
module pipeCtrl (
	input  logic                 clk,
	// synchronous, active low
	input  logic                 rstN,
	// data memory not ready
	input  logic                 dWait,
	// decoded control of the instruction in Decode
	input  pipePkg::stageCtrl_t  ctrlD,
	// branch, jump and jalr of the instruction in Decode
	input  pipePkg::branchInfo_t brInfoD,
	// bypass selects toward the datapath
	output pipePkg::forward_t    fwd,
	// stall and flush commands toward the datapath
	output pipePkg::hazardCmd_t  cmd,
	// registered stage contents
	output pipePkg::stageCtrl_t  ctrlE,
	output pipePkg::stageCtrl_t  ctrlM,
	output pipePkg::stageCtrl_t  ctrlW
);

	// back end moves forward this cycle
	logic advance;
	// value Execute takes on the next edge
	pipePkg::stageCtrl_t nextE;

	// the whole back end holds as one on a memory wait
	assign advance = ~cmd.stallBack;

	// Decode instruction or a bubble when Decode is held back
	always_comb begin
		if (cmd.flushE) begin
			nextE = pipePkg::ctrlBubble;
		end else begin
			nextE = ctrlD;
		end
	end

	// Execute control register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlE <= pipePkg::ctrlBubble;
		end else if (advance) begin
			ctrlE <= nextE;
		end
	end

	// Memory control register
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlM <= pipePkg::ctrlBubble;
		end else if (advance) begin
			ctrlM <= ctrlE;
		end
	end

	// Writeback control register
	// last stage so a held value simply repeats its write
	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlW <= pipePkg::ctrlBubble;
		end else if (advance) begin
			ctrlW <= ctrlM;
		end
	end

	// operand bypass from the registered stages
	forwardUnit u_forwardUnit (
		.ctrlD (ctrlD),
		.ctrlE (ctrlE),
		.ctrlM (ctrlM),
		.ctrlW (ctrlW),
		.fwd   (fwd)
	);

	// stalls and flushes
	// Writeback never blocks Decode so it is not needed here
	hazardUnit u_hazardUnit (
		.ctrlD   (ctrlD),
		.ctrlE   (ctrlE),
		.ctrlM   (ctrlM),
		.brInfoD (brInfoD),
		.dWait   (dWait),
		.cmd     (cmd)
	);

endmodule

//--- verification/pipeCheck.sv
////////////////////////////////////////
// checker for pipeCtrl, samples every rising clk
// keeps its own Execute, Memory and Writeback model
////////////////////////////////////////
module pipeCheck (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 dWait,
	input  pipePkg::stageCtrl_t  ctrlD,
	input  pipePkg::branchInfo_t brInfoD,
	input  pipePkg::forward_t    fwd,
	input  pipePkg::hazardCmd_t  cmd,
	input  pipePkg::stageCtrl_t  ctrlE,
	input  pipePkg::stageCtrl_t  ctrlM,
	input  pipePkg::stageCtrl_t  ctrlW,
	// failed checks so far
	output int                   errors,
	// cycles checked out of reset
	output int                   cycles
);
	timeunit 1ns;
	timeprecision 1ps;

	// model of the three stage registers
	pipePkg::stageCtrl_t mE;
	pipePkg::stageCtrl_t mM;
	pipePkg::stageCtrl_t mW;
	// stage contents seen at the previous edge
	pipePkg::stageCtrl_t prevE;
	pipePkg::stageCtrl_t prevM;
	pipePkg::stageCtrl_t prevW;
	// a reset edge has been seen
	logic started;
	// first edge after reset
	logic afterReset;
	// Execute must read as a bubble at this edge
	logic pendBubble;
	// back end must be unchanged at this edge
	logic pendHold;

	// derived conditions of the current cycle
	logic memAcc;
	logic memStall;
	logic loadUse;
	logic brStall;
	logic expFlushD;
	logic expFlushE;
	pipePkg::fwdSel_t expAE;
	pipePkg::fwdSel_t expBE;
	pipePkg::hazardCmd_t expCmd;

	// Execute operand source, Memory first, r0 never forwards
	function automatic pipePkg::fwdSel_t expExec(
		input pipePkg::regAddr_t   src,
		input pipePkg::stageCtrl_t m,
		input pipePkg::stageCtrl_t w
	);
		if (src == '0) begin
			return pipePkg::fwdNone;
		end
		if (m.regWrite && (m.writeReg == src)) begin
			return pipePkg::fwdM;
		end
		if (w.regWrite && (w.writeReg == src)) begin
			return pipePkg::fwdW;
		end
		return pipePkg::fwdNone;
	endfunction

	// Decode source served from the Memory writer
	function automatic logic expDecode(
		input pipePkg::regAddr_t   src,
		input pipePkg::stageCtrl_t m
	);
		return (src != '0) && m.regWrite && (m.writeReg == src);
	endfunction

	// dest is read by the Decode instruction, r0 included
	function automatic logic readByD(
		input pipePkg::stageCtrl_t d,
		input pipePkg::regAddr_t   dest
	);
		return (dest == d.rs) || (dest == d.rt);
	endfunction

	task automatic flagError(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	initial begin
		errors = 0;
		cycles = 0;
		started = 1'b0;
		afterReset = 1'b0;
		pendBubble = 1'b0;
		pendHold = 1'b0;
	end

	always @(posedge clk) begin
		if (!rstN) begin
			mE = '0;
			mM = '0;
			mW = '0;
			started = 1'b1;
			afterReset = 1'b1;
			pendBubble = 1'b0;
			pendHold = 1'b0;
		end else if (started) begin
			cycles++;
			// expected hazards straight from the stage contents
			memAcc = ctrlM.memToReg || ctrlM.memWrite;
			memStall = dWait && memAcc;
			loadUse = ctrlE.memToReg && readByD(ctrlD, ctrlE.writeReg);
			brStall = (brInfoD.branch || brInfoD.jalr)
				&& ((ctrlE.regWrite && readByD(ctrlD, ctrlE.writeReg))
				|| (ctrlM.memToReg && readByD(ctrlD, ctrlM.writeReg)));
			expFlushD = !memStall && ((brInfoD.branch && brInfoD.brTaken && !brStall)
				|| brInfoD.jump || (brInfoD.jalr && !brStall));
			expFlushE = (loadUse || brStall) && !memStall;
			expAE = expExec(ctrlE.rs, ctrlM, ctrlW);
			expBE = expExec(ctrlE.rt, ctrlM, ctrlW);
			expCmd.stallF = loadUse || brStall || memStall;
			expCmd.stallD = loadUse || brStall || memStall;
			expCmd.flushD = expFlushD;
			expCmd.flushE = expFlushE;
			expCmd.stallBack = memStall;
			expCmd.memAccessM = memAcc;

			// reset leaves bubbles everywhere
			if (afterReset) begin
				assert (ctrlE == '0 && ctrlM == '0 && ctrlW == '0)
					else flagError("stage registers are not bubbles after reset");
			end
			assert (ctrlE == mE && ctrlM == mM && ctrlW == mW)
				else flagError($sformatf("stages E/M/W %h/%h/%h, expected %h/%h/%h",
					ctrlE, ctrlM, ctrlW, mE, mM, mW));
			// bubble after a load-use or branch stall
			if (pendBubble) begin
				assert (ctrlE == '0)
					else flagError($sformatf("ctrlE is %h, expected a bubble", ctrlE));
			end
			// held back end or plain advance
			if (pendHold) begin
				assert (ctrlE == prevE && ctrlM == prevM && ctrlW == prevW)
					else flagError("back end changed during a memory wait");
			end else if (!afterReset) begin
				assert (ctrlM == prevE && ctrlW == prevM)
					else flagError($sformatf("ctrlM/ctrlW %h/%h, expected %h/%h",
						ctrlM, ctrlW, prevE, prevM));
			end

			// Execute bypass
			assert (fwd.forwardAE == expAE)
				else flagError($sformatf("forwardAE is %0d, expected %0d", fwd.forwardAE, expAE));
			assert (fwd.forwardBE == expBE)
				else flagError($sformatf("forwardBE is %0d, expected %0d", fwd.forwardBE, expBE));
			// Decode bypass
			assert (fwd.forwardAD == expDecode(ctrlD.rs, ctrlM))
				else flagError($sformatf("forwardAD is %0d", fwd.forwardAD));
			assert (fwd.forwardBD == expDecode(ctrlD.rt, ctrlM))
				else flagError($sformatf("forwardBD is %0d", fwd.forwardBD));
			// load-use and branch stall
			if ((loadUse || brStall) && !memStall) begin
				assert (cmd.stallF && cmd.stallD && cmd.flushE)
					else flagError($sformatf("stall or flushE missing, cmd %b", cmd));
			end
			// control flow flush
			assert (cmd.flushD == expFlushD)
				else flagError($sformatf("flushD is %0d, expected %0d", cmd.flushD, expFlushD));
			// memory wait
			if (memStall) begin
				assert (cmd.stallBack && cmd.stallF && cmd.stallD && !cmd.flushD
					&& !cmd.flushE && cmd.memAccessM)
					else flagError($sformatf("bad memory wait commands, cmd %b", cmd));
			end
			assert (cmd == expCmd)
				else flagError($sformatf("cmd is %b, expected %b", cmd, expCmd));

			// what the next edge has to show
			pendBubble = expFlushE;
			pendHold = memStall;
			prevE = ctrlE;
			prevM = ctrlM;
			prevW = ctrlW;
			afterReset = 1'b0;
			if (!memStall) begin
				mW = mM;
				mM = mE;
				mE = expFlushE ? pipePkg::stageCtrl_t'('0) : ctrlD;
			end
		end
	end

endmodule

//--- verification/pipeCtrlTb.sv
////////////////////////////////////////
// random run of pipeCtrl, checking lives in pipeCheck
// addresses 0 to 3 only, so matches are frequent
////////////////////////////////////////
module pipeCtrlTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 8;
	localparam int numCycles = 5000;
	localparam logic [31:0] seed = 32'd60620;
	// stimulus length plus a margin for the closing edges
	localparam int timeLimit = (resetCycles + numCycles + 50) * clkPeriod;

	logic clk;
	logic rstN;
	logic dWait;
	pipePkg::stageCtrl_t ctrlD;
	pipePkg::branchInfo_t brInfoD;
	pipePkg::forward_t fwd;
	pipePkg::hazardCmd_t cmd;
	pipePkg::stageCtrl_t ctrlE;
	pipePkg::stageCtrl_t ctrlM;
	pipePkg::stageCtrl_t ctrlW;
	int errors;
	int cycles;
	logic [31:0] rngState;
	// Decode was stalled at the last edge
	logic holdD;

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic nextRandom(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	// new Decode instruction with weighted opcode class
	task automatic drawInstr();
		logic [31:0] r;
		int pick;
		pipePkg::stageCtrl_t c;
		pipePkg::branchInfo_t b;
		nextRandom(r);
		pick = r % 100;
		nextRandom(r);
		c = '0;
		b = '0;
		c.rs = pipePkg::regAddr_t'(r[1:0]);
		c.rt = pipePkg::regAddr_t'(r[3:2]);
		c.writeReg = pipePkg::regAddr_t'(r[5:4]);
		// comparator output is present whatever the opcode
		b.brTaken = r[8];
		if (pick < 25) begin
			// load
			c.regWrite = 1'b1;
			c.memToReg = 1'b1;
		end else if (pick < 40) begin
			// store, no destination
			c.memWrite = 1'b1;
			c.writeReg = '0;
		end else if (pick < 70) begin
			// ALU op
			c.regWrite = 1'b1;
		end else if (pick < 85) begin
			b.branch = 1'b1;
			c.writeReg = '0;
		end else if (pick < 90) begin
			b.jump = 1'b1;
			c.writeReg = '0;
		end else begin
			// jalr writes its link register
			b.jalr = 1'b1;
			c.regWrite = 1'b1;
		end
		ctrlD = c;
		brInfoD = b;
	endtask

	// data memory busy about one cycle in five
	task automatic drawWait();
		logic [31:0] r;
		nextRandom(r);
		dWait = (r % 5) == 0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// stalled Decode keeps its instruction
	always @(posedge clk) begin
		holdD <= rstN && cmd.stallD;
	end

	pipeCtrl u_pipeCtrl (
		.clk     (clk),
		.rstN    (rstN),
		.dWait   (dWait),
		.ctrlD   (ctrlD),
		.brInfoD (brInfoD),
		.fwd     (fwd),
		.cmd     (cmd),
		.ctrlE   (ctrlE),
		.ctrlM   (ctrlM),
		.ctrlW   (ctrlW)
	);

	pipeCheck u_pipeCheck (
		.clk     (clk),
		.rstN    (rstN),
		.dWait   (dWait),
		.ctrlD   (ctrlD),
		.brInfoD (brInfoD),
		.fwd     (fwd),
		.cmd     (cmd),
		.ctrlE   (ctrlE),
		.ctrlM   (ctrlM),
		.ctrlW   (ctrlW),
		.errors  (errors),
		.cycles  (cycles)
	);

	// stimulus on the falling edge
	initial begin
		rstN = 1'b0;
		dWait = 1'b0;
		ctrlD = '0;
		brInfoD = '0;
		holdD = 1'b0;
		rngState = seed;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		repeat (numCycles) begin
			@(negedge clk);
			if (!holdD) begin
				drawInstr();
			end
			drawWait();
		end
		// let the last inputs be sampled
		repeat (2) @(negedge clk);
		$display("pipeCtrlTb: %0d cycles checked, %0d errors", cycles, errors);
		if (errors == 0 && cycles > 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(timeLimit);
		$display("Timeout: the run did not finish within %0d ns", timeLimit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tb.f
source/pipePkg.sv
source/forwardUnit.sv
source/hazardUnit.sv
source/pipeCtrl.sv
verification/pipeCheck.sv
verification/pipeCtrlTb.sv
